/* hw/mtsp_pkg.sv */
// MTSP decode definitions
`default_nettype none

package mtsp_pkg;

	//==========================================================================
	// Widths
	//==========================================================================
	localparam int DWORD_W    = 32;
	localparam int GPR_ADDR_W = 8;
	localparam int OPCODE_W   = 5;
	localparam int LANES      = 4;

	// Data and address words
	typedef logic [DWORD_W-1:0]    dword_t;
	typedef dword_t [LANES-1:0]    vec4_t;		// lane x in [31:0]
	typedef logic [GPR_ADDR_W-1:0] gpr_addr_t;
	typedef logic [DWORD_W-1:0]    pc_t;

	//==========================================================================
	// Unit instruction word
	//==========================================================================
	// ALU form, is_mem low
	typedef struct packed {
		logic                  is_mem;
		logic [OPCODE_W-1:0]   opcode;
		logic [LANES-1:0]      mask;
		logic [5:0]            dest_off;
		logic [2*LANES-1:0]    swizzle;	// two bits per lane, x in [1:0]
		logic [GPR_ADDR_W-1:0] src;
	} uinst_alu_t;

	// Memory form, is_mem high
	typedef struct packed {
		logic                  is_mem;
		logic [OPCODE_W-1:0]   mem_op;
		logic [LANES-1:0]      mask;
		logic [5:0]            dest_off;
		logic [7:0]            imm;
		logic [GPR_ADDR_W-1:0] src;
	} uinst_mem_t;

	// Same word seen both ways, form bit at the top of each
	typedef union packed {
		uinst_alu_t alu;
		uinst_mem_t mem;
	} uinst_u;

	// Main and sub per phase
	typedef struct packed {
		uinst_u p0_m;
		uinst_u p0_s;
		uinst_u p1_m;
		uinst_u p1_s;
	} uinst_x4_t;

	//==========================================================================
	// Micro-operations and stage bundles
	//==========================================================================
	typedef struct packed {
		logic                en;
		logic [OPCODE_W-1:0] opcode;
	} mo_lane_t;

	typedef struct packed {
		mo_lane_t         x;
		mo_lane_t         y;
		mo_lane_t         z;
		mo_lane_t         w;
		logic [LANES-1:0] mask;		// bit 0 is lane x
		gpr_addr_t        waddr;
	} mo_t;

	// Into the decode stage
	typedef struct packed {
		logic      valid;
		pc_t       pc;
		uinst_x4_t uinst;
		vec4_t     src0a;
		vec4_t     src0b;
		vec4_t     src1a;
		vec4_t     src1b;
		gpr_addr_t ref_addr_dest;
	} dec_in_t;

	// Toward execution
	typedef struct packed {
		logic      valid;
		pc_t       pc;
		uinst_x4_t uinst;
		gpr_addr_t ref_mem_src;
		vec4_t     src0a;
		vec4_t     src0b;
		vec4_t     src1a;
		vec4_t     src1b;
		mo_t       mo0;
		mo_t       mo1;
	} dec_out_t;

	// Lane mask an instruction claims; memory form claims none
	function automatic logic [LANES-1:0] alu_mask(input uinst_u u);
		return u.mem.is_mem ? '0 : u.alu.mask;
	endfunction

endpackage

`default_nettype wire

/* hw/decode_latch.sv */
// Decode input latch
`default_nettype none
`timescale 1ns/100ps

module decode_latch (
	input  wire logic              clk,
	input  wire logic              rst_n,
	// Bundle from register read
	input  wire mtsp_pkg::dec_in_t bundle_in,
	// Registered bundle to decode
	output mtsp_pkg::dec_in_t      bundle
);

	//==========================================================================
	// Input register
	//==========================================================================
	// Whole bundle loads on the strobe
	// Payload holds otherwise, only valid drops
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bundle.valid <= 1'b0;
		end else if (bundle_in.valid) begin
			bundle <= bundle_in;
		end else begin
			bundle.valid <= 1'b0;
		end
	end

	// Strobe must be a known level out of reset
	a_strobe_known: assert property (
		@(posedge clk) rst_n |-> !$isunknown(bundle_in.valid)
	) else $error("decode_latch: valid strobe unknown");

endmodule

`default_nettype wire

/* hw/src_swizzle.sv */
// Source vector lane swizzle
`default_nettype none
`timescale 1ns/100ps

module src_swizzle (
	input  wire logic            sel_en,
	// Two bits per output lane, x in [1:0]
	input  wire logic [7:0]      swizzle,
	input  wire mtsp_pkg::vec4_t vec_in,
	output mtsp_pkg::vec4_t      vec_out
);

	//==========================================================================
	// Lane select
	//==========================================================================
	always_comb begin
		for (int i = 0; i < mtsp_pkg::LANES; i++) begin
			// Each output lane picks any input lane
			if (sel_en) begin
				vec_out[i] = vec_in[swizzle[2*i +: 2]];
			end else begin
				vec_out[i] = vec_in[i];
			end
		end
	end

	// Bypass must leave the vector untouched
	a_pass: assert final (
		sel_en || vec_out == vec_in
	) else $error("src_swizzle: pass-through altered the vector");

endmodule

`default_nettype wire

/* hw/mo_dispatch.sv */
// Micro-operation dispatch
`default_nettype none
`timescale 1ns/100ps

module mo_dispatch (
	input  wire mtsp_pkg::uinst_x4_t uinst,
	// Base for both write addresses
	input  wire mtsp_pkg::gpr_addr_t ref_addr_dest,
	// Phase 0 and phase 1 descriptors
	output mtsp_pkg::mo_t            mo0,
	output mtsp_pkg::mo_t            mo1
);

	//==========================================================================
	// One phase
	//==========================================================================
	// Main word owns its lanes, sub word fills what is left
	function automatic mtsp_pkg::mo_t build_mo(
		input mtsp_pkg::uinst_u    main_i,
		input mtsp_pkg::uinst_u    sub_i,
		input mtsp_pkg::gpr_addr_t base
	);
		mtsp_pkg::mo_t                             mo;
		mtsp_pkg::mo_lane_t [mtsp_pkg::LANES-1:0]  lane;
		logic               [mtsp_pkg::LANES-1:0]  m_mask;
		logic               [mtsp_pkg::LANES-1:0]  s_mask;

		// Memory form words claim no lanes
		m_mask = mtsp_pkg::alu_mask(main_i);
		s_mask = mtsp_pkg::alu_mask(sub_i);

		for (int i = 0; i < mtsp_pkg::LANES; i++) begin
			if (m_mask[i]) begin
				lane[i].en     = 1'b1;
				lane[i].opcode = main_i.alu.opcode;
			end else if (s_mask[i]) begin
				lane[i].en     = 1'b1;
				lane[i].opcode = sub_i.alu.opcode;
			end else begin
				// Idle lane
				lane[i].en     = 1'b0;
				lane[i].opcode = '0;
			end
		end

		// Lane 0 is x
		mo.x = lane[0];
		mo.y = lane[1];
		mo.z = lane[2];
		mo.w = lane[3];

		mo.mask = m_mask | s_mask;

		// dest_off sits at the same bits in both forms
		// 8-bit sum wraps past 255
		mo.waddr = base + mtsp_pkg::gpr_addr_t'(main_i.alu.dest_off);

		return mo;
	endfunction

	//==========================================================================
	// Both phases
	//==========================================================================
	always_comb begin
		mo0 = build_mo(uinst.p0_m, uinst.p0_s, ref_addr_dest);
		mo1 = build_mo(uinst.p1_m, uinst.p1_s, ref_addr_dest);
	end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
// Decode stage 3
`default_nettype none
`timescale 1ns/100ps

module decode_stage (
	// Sampling clock for checks only
	input  wire logic              clk,
	input  wire mtsp_pkg::dec_in_t bundle,
	output mtsp_pkg::dec_out_t     result
);

	mtsp_pkg::uinst_u    p1_m;
	mtsp_pkg::uinst_u    p1_s;
	logic                p1_s_alu;
	mtsp_pkg::vec4_t     src1b_swz;
	mtsp_pkg::mo_t       mo0;
	mtsp_pkg::mo_t       mo1;

	assign p1_m     = bundle.uinst.p1_m;
	assign p1_s     = bundle.uinst.p1_s;
	assign p1_s_alu = !p1_s.mem.is_mem;

	//==========================================================================
	// Datapath
	//==========================================================================
	// Phase 1 sub swizzle reorders src1b
	src_swizzle u_src1b_swz (
		.sel_en  (p1_s_alu),
		.swizzle (p1_s.alu.swizzle),
		.vec_in  (bundle.src1b),
		.vec_out (src1b_swz)
	);

	mo_dispatch u_mo_dispatch (
		.uinst         (bundle.uinst),
		.ref_addr_dest (bundle.ref_addr_dest),
		.mo0           (mo0),
		.mo1           (mo1)
	);

	always_comb begin
		result.valid = bundle.valid;
		result.pc    = bundle.pc;
		result.uinst = bundle.uinst;
		result.src0a = bundle.src0a;
		result.src0b = bundle.src0b;
		result.src1a = bundle.src1a;
		result.src1b = src1b_swz;
		// Top two bits from the sub swizzle, ALU form only
		if (p1_s_alu) begin
			result.ref_mem_src = {p1_s.alu.swizzle[7:6], p1_m.alu.src[5:0]};
		end else begin
			result.ref_mem_src = p1_m.alu.src;
		end
		result.mo0 = mo0;
		result.mo1 = mo1;
	end

	// Main and sub never claim the same lane
	a_mask_p0: assert property (@(posedge clk) bundle.valid |->
		(mtsp_pkg::alu_mask(bundle.uinst.p0_m) & mtsp_pkg::alu_mask(bundle.uinst.p0_s)) == '0
	) else $error("decode_stage: phase 0 masks overlap");

	a_mask_p1: assert property (@(posedge clk) bundle.valid |->
		(mtsp_pkg::alu_mask(p1_m) & mtsp_pkg::alu_mask(p1_s)) == '0
	) else $error("decode_stage: phase 1 masks overlap");

	a_valid: assert property (@(posedge clk) result.valid == bundle.valid)
		else $error("decode_stage: valid not forwarded");

endmodule

`default_nettype wire

/* hw/issue_latch.sv */
// Issue output latch
`default_nettype none
`timescale 1ns/100ps

module issue_latch (
	input  wire logic               clk,
	input  wire logic               rst_n,
	// Decoded bundle, combinational
	input  wire mtsp_pkg::dec_out_t result,
	// Toward execution
	output mtsp_pkg::dec_out_t      issue_out
);

	//==========================================================================
	// Output register
	//==========================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue_out.valid <= 1'b0;
		end else if (result.valid) begin
			issue_out <= result;
		end else begin
			// Keep payload, drop valid
			issue_out.valid <= 1'b0;
		end
	end

	// Nothing issues on the cycle after a reset edge
	a_rst_quiet: assert property (
		@(posedge clk) !rst_n |=> !issue_out.valid
	) else $error("issue_latch: valid high right after reset");

endmodule

`default_nettype wire

/* hw/decode_top.sv */
// Decode subsystem top
`default_nettype none
`timescale 1ns/100ps

module decode_top (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire mtsp_pkg::dec_in_t bundle_in,
	output mtsp_pkg::dec_out_t     issue_out
);

	// Latched bundle and its decode
	mtsp_pkg::dec_in_t  bundle;
	mtsp_pkg::dec_out_t result;

	//==========================================================================
	// Two-cycle pipe, latch then decode then issue
	//==========================================================================
	decode_latch u_decode_latch (
		.clk       (clk),
		.rst_n     (rst_n),
		.bundle_in (bundle_in),
		.bundle    (bundle)
	);

	decode_stage u_decode_stage (
		.clk    (clk),
		.bundle (bundle),
		.result (result)
	);

	issue_latch u_issue_latch (
		.clk       (clk),
		.rst_n     (rst_n),
		.result    (result),
		.issue_out (issue_out)
	);

endmodule

`default_nettype wire

/* sim/decode_tb.sv */
// Decode subsystem testbench
`default_nettype none
`timescale 1ns/100ps

module decode_tb;

	localparam int NTEST   = 6;
	localparam int TIMEOUT = 20;

	// One table row, words in bundle order
	typedef struct {
		string               name;
		logic [31:0]         p0_m;
		logic [31:0]         p0_s;
		logic [31:0]         p1_m;
		logic [31:0]         p1_s;
		mtsp_pkg::gpr_addr_t base;
		mtsp_pkg::mo_t       mo0;
		mtsp_pkg::mo_t       mo1;
		mtsp_pkg::gpr_addr_t ref_src;
	} test_t;

	logic               clk;
	logic               rst_n;
	mtsp_pkg::dec_in_t  bundle_in;
	mtsp_pkg::dec_out_t issue_out;

	test_t           tbl [NTEST];
	mtsp_pkg::vec4_t exp_src [NTEST][4];	// src0a, src0b, src1a, swizzled src1b
	mtsp_pkg::pc_t   exp_pc [NTEST];
	int              drive_cyc [NTEST];
	logic [31:0]     lfsr;
	int              cyc = 0;
	int              errors;
	int              passed;
	int              failed;
	bit              timed_out;

	decode_top uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.bundle_in (bundle_in),
		.issue_out (issue_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Edge counter for latency
	always @(posedge clk) cyc <= cyc + 1;

	//==========================================================================
	// Stimulus helpers
	//==========================================================================
	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_word();
		logic        fb;
		logic [31:0] w;
		for (int i = 0; i < 32; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			w    = {w[30:0], fb};
		end
		return w;
	endfunction

	function automatic mtsp_pkg::vec4_t rand_vec();
		return {rand_word(), rand_word(), rand_word(), rand_word()};
	endfunction

	// is_mem, op, mask, dest_off, swizzle or imm, src
	function automatic logic [31:0] alu_word(input logic [4:0] op, input logic [3:0] mask,
		input logic [5:0] doff, input logic [7:0] swz, input logic [7:0] src);
		return {1'b0, op, mask, doff, swz, src};
	endfunction

	function automatic logic [31:0] mem_word(input logic [4:0] op, input logic [3:0] mask,
		input logic [5:0] doff, input logic [7:0] imm, input logic [7:0] src);
		return {1'b1, op, mask, doff, imm, src};
	endfunction

	// Lane enabled exactly where the merged mask is set
	function automatic mtsp_pkg::mo_t make_mo(input logic [4:0] ox, input logic [4:0] oy,
		input logic [4:0] oz, input logic [4:0] ow, input logic [3:0] mask,
		input mtsp_pkg::gpr_addr_t waddr);
		mtsp_pkg::mo_t mo;
		mo.x     = {mask[0], ox};
		mo.y     = {mask[1], oy};
		mo.z     = {mask[2], oz};
		mo.w     = {mask[3], ow};
		mo.mask  = mask;
		mo.waddr = waddr;
		return mo;
	endfunction

	// Output lane i takes input lane swizzle[2i+1:2i], memory form passes
	function automatic mtsp_pkg::vec4_t swizzle_ref(input logic [31:0] word,
		input mtsp_pkg::vec4_t v);
		mtsp_pkg::vec4_t r;
		for (int i = 0; i < 4; i++) begin
			r[i] = word[31] ? v[i] : v[word[8 + 2*i +: 2]];
		end
		return r;
	endfunction

	task automatic add_test(input int k, input string name, input logic [31:0] w0,
		input logic [31:0] w1, input logic [31:0] w2, input logic [31:0] w3,
		input mtsp_pkg::gpr_addr_t base, input mtsp_pkg::mo_t mo0,
		input mtsp_pkg::mo_t mo1, input mtsp_pkg::gpr_addr_t ref_src);
		tbl[k] = '{name, w0, w1, w2, w3, base, mo0, mo1, ref_src};
	endtask

	//==========================================================================
	// Stimulus table
	//==========================================================================
	task automatic load_table();
		// Identity swizzle, main and sub split each phase
		add_test(0, "ident_split", alu_word(1, 4'b0011, 2, 8'hE4, 8'h10),
			alu_word(2, 4'b1100, 5, 8'h00, 8'h00), alu_word(3, 4'b0101, 7, 8'h00, 8'h3C),
			alu_word(4, 4'b1010, 0, 8'hE4, 8'h00), 8'h10,
			make_mo(1, 1, 2, 2, 4'b1111, 8'h12), make_mo(3, 4, 3, 4, 4'b1111, 8'h17), 8'hFC);
		// Reverse swizzle, memory sub in phase 0
		add_test(1, "reverse_mem_sub", alu_word(5, 4'b0001, 1, 8'h00, 8'h00),
			mem_word(9, 4'b1110, 0, 8'h33, 8'h00), alu_word(6, 4'b0110, 3, 8'h00, 8'hC5),
			alu_word(7, 4'b1000, 0, 8'h1B, 8'h00), 8'h20,
			make_mo(5, 0, 0, 0, 4'b0001, 8'h21), make_mo(0, 6, 6, 7, 4'b1110, 8'h23), 8'h05);
		// Broadcast y, phase 0 address wraps
		add_test(2, "bcast_wrap", alu_word(8, 4'b1111, 63, 8'h00, 8'h00),
			alu_word(9, 4'b0000, 0, 8'h00, 8'h00), alu_word(10, 4'b0011, 10, 8'h00, 8'h01),
			alu_word(11, 4'b0100, 0, 8'h55, 8'h00), 8'hF0,
			make_mo(8, 8, 8, 8, 4'b1111, 8'h2F), make_mo(10, 10, 11, 0, 4'b0111, 8'hFA), 8'h41);
		// Memory p1 sub, src1b and ref source untouched
		add_test(3, "mem_p1_sub", mem_word(3, 4'b1111, 4, 8'h00, 8'h00),
			alu_word(12, 4'b0110, 9, 8'h00, 8'h00), alu_word(13, 4'b1001, 20, 8'h00, 8'hAB),
			mem_word(2, 4'b0110, 0, 8'h55, 8'h00), 8'h80,
			make_mo(0, 12, 12, 0, 4'b0110, 8'h84), make_mo(13, 0, 0, 13, 4'b1001, 8'h94), 8'hAB);
		// No lanes at all, base wraps to zero
		add_test(4, "all_mem", mem_word(1, 4'b1111, 63, 8'h00, 8'h00),
			mem_word(2, 4'b0011, 0, 8'h00, 8'h00), mem_word(3, 4'b1100, 1, 8'h12, 8'h7E),
			mem_word(4, 4'b1111, 0, 8'hFF, 8'h00), 8'hC1,
			make_mo(0, 0, 0, 0, 4'b0000, 8'h00), make_mo(0, 0, 0, 0, 4'b0000, 8'hC2), 8'h7E);
		// Broadcast w, sub words own every lane
		add_test(5, "bcast_w_sub", alu_word(1, 4'b0000, 0, 8'h00, 8'h00),
			alu_word(31, 4'b1111, 0, 8'h00, 8'h00), alu_word(0, 4'b0000, 32, 8'h00, 8'h00),
			alu_word(17, 4'b1111, 0, 8'hFF, 8'h00), 8'hFF,
			make_mo(31, 31, 31, 31, 4'b1111, 8'hFF), make_mo(17, 17, 17, 17, 4'b1111, 8'h1F),
			8'hC0);
	endtask

	//==========================================================================
	// Compare tasks
	//==========================================================================
	task automatic check_mo(input string tn, input string what,
		input mtsp_pkg::mo_t exp, input mtsp_pkg::mo_t got);
		if (got !== exp) begin
			errors++;
			$display("Fail %s %s: expected %h, got %h", tn, what, exp, got);
		end
	endtask

	task automatic check_vec(input string tn, input string what,
		input mtsp_pkg::vec4_t exp, input mtsp_pkg::vec4_t got);
		if (got !== exp) begin
			errors++;
			$display("Fail %s %s: expected %h, got %h", tn, what, exp, got);
		end
	endtask

	task automatic check_addr(input string tn, input string what,
		input mtsp_pkg::gpr_addr_t exp, input mtsp_pkg::gpr_addr_t got);
		if (got !== exp) begin
			errors++;
			$display("Fail %s %s: expected %h, got %h", tn, what, exp, got);
		end
	endtask

	task automatic check_pc(input string tn, input string what,
		input mtsp_pkg::pc_t exp, input mtsp_pkg::pc_t got);
		if (got !== exp) begin
			errors++;
			$display("Fail %s %s: expected %h, got %h", tn, what, exp, got);
		end
	endtask

	task automatic check_latency(input string tn, input int exp, input int got);
		if (got != exp) begin
			errors++;
			$display("Fail %s latency: expected %0d, got %0d", tn, exp, got);
		end
	endtask

	//==========================================================================
	// Drive and check one bundle
	//==========================================================================
	task automatic drive_entry(input int k);
		bundle_in.valid         = 1'b1;
		bundle_in.pc            = 32'h0000_4000 + 32'(k) * 16;
		bundle_in.uinst         = {tbl[k].p0_m, tbl[k].p0_s, tbl[k].p1_m, tbl[k].p1_s};
		bundle_in.src0a         = rand_vec();
		bundle_in.src0b         = rand_vec();
		bundle_in.src1a         = rand_vec();
		bundle_in.src1b         = rand_vec();
		bundle_in.ref_addr_dest = tbl[k].base;
		exp_pc[k]     = bundle_in.pc;
		exp_src[k][0] = bundle_in.src0a;
		exp_src[k][1] = bundle_in.src0b;
		exp_src[k][2] = bundle_in.src1a;
		exp_src[k][3] = swizzle_ref(tbl[k].p1_s, bundle_in.src1b);
		drive_cyc[k]  = cyc;
	endtask

	task automatic check_result(input int k);
		string tn;
		tn = tbl[k].name;
		check_latency(tn, drive_cyc[k] + 2, cyc);
		check_pc(tn, "pc", exp_pc[k], issue_out.pc);
		check_vec(tn, "uinst", {tbl[k].p0_m, tbl[k].p0_s, tbl[k].p1_m, tbl[k].p1_s},
			mtsp_pkg::vec4_t'(issue_out.uinst));
		check_vec(tn, "src0a", exp_src[k][0], issue_out.src0a);
		check_vec(tn, "src0b", exp_src[k][1], issue_out.src0b);
		check_vec(tn, "src1a", exp_src[k][2], issue_out.src1a);
		check_vec(tn, "src1b", exp_src[k][3], issue_out.src1b);
		check_mo(tn, "mo0", tbl[k].mo0, issue_out.mo0);
		check_mo(tn, "mo1", tbl[k].mo1, issue_out.mo1);
		check_addr(tn, "ref_mem_src", tbl[k].ref_src, issue_out.ref_mem_src);
	endtask

	task automatic report(input string tn, input int e0);
		if (errors == e0) begin
			passed++;
			$display("done %s: no mismatches", tn);
		end else begin
			failed++;
			$display("done %s: %0d mismatches", tn, errors - e0);
		end
	endtask

	//==========================================================================
	// Main sequence
	//==========================================================================
	initial begin
		int e0;
		rst_n     = 1'b0;
		bundle_in = '0;
		lfsr      = 32'h6962;
		errors    = 0;
		passed    = 0;
		failed    = 0;
		timed_out = 1'b0;
		load_table();
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;

		// Quiet until the first strobe
		e0 = errors;
		repeat (4) begin
			@(posedge clk);
			#2;
			if (issue_out.valid !== 1'b0) begin
				errors++;
				$display("issue_out valid rose with no bundle strobed");
			end
		end
		report("idle", e0);

		fork
			// Back-to-back strobes, one idle gap before row 3
			begin
				for (int k = 0; k < NTEST; k++) begin
					@(posedge clk);
					#1;
					if (k == 3) begin
						bundle_in.valid = 1'b0;
						@(posedge clk);
						#1;
					end
					drive_entry(k);
				end
				@(posedge clk);
				#1 bundle_in.valid = 1'b0;
			end
			// Results in order
			begin
				int t;
				int em;
				for (int k = 0; k < NTEST; k++) begin
					em = errors;
					t  = 0;
					do begin
						@(posedge clk);
						#2;
						t++;
					end while (issue_out.valid !== 1'b1 && t < TIMEOUT);
					if (issue_out.valid !== 1'b1) begin
						$display("No bundle came out for %s within %0d cycles", tbl[k].name,
							TIMEOUT);
						timed_out = 1'b1;
						break;
					end
					check_result(k);
					report(tbl[k].name, em);
				end
			end
		join

		// Reset with two bundles in flight
		e0 = errors;
		@(posedge clk);
		#1 drive_entry(0);
		@(posedge clk);
		#1 drive_entry(1);
		@(posedge clk);
		#1;
		// A third strobe held through reset must never load
		drive_entry(2);
		rst_n = 1'b0;
		if (issue_out.valid !== 1'b1) begin
			errors++;
			$display("first bundle did not issue before the reset");
		end
		repeat (2) begin
			@(posedge clk);
			#1;
			if (issue_out.valid !== 1'b0) begin
				errors++;
				$display("issue_out valid stayed high during reset");
			end
		end
		bundle_in.valid = 1'b0;
		rst_n           = 1'b1;
		repeat (6) begin
			@(posedge clk);
			#2;
			if (issue_out.valid !== 1'b0) begin
				errors++;
				$display("a stale bundle issued after reset");
			end
		end
		report("mid_reset", e0);

		$display("%0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
		if (errors == 0 && !timed_out) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
hw/mtsp_pkg.sv
hw/decode_latch.sv
hw/src_swizzle.sv
hw/mo_dispatch.sv
hw/decode_stage.sv
hw/issue_latch.sv
hw/decode_top.sv
sim/decode_tb.sv

/* Bender.yml */
package:
  name: mtsp_decode

sources:
  - files:
      - hw/mtsp_pkg.sv
      - hw/decode_latch.sv
      - hw/src_swizzle.sv
      - hw/mo_dispatch.sv
      - hw/decode_stage.sv
      - hw/issue_latch.sv
      - hw/decode_top.sv
  - target: test
    files:
      - sim/decode_tb.sv
